// ==== verilog/conv_tile_defines.svh ====
// tile sizes and data widths shared by the convolution engine
// include this in any file that sizes a buffer, a port or a loop
`ifndef CONV_TILE_DEFINES_SVH
`define CONV_TILE_DEFINES_SVH

`define CT_DW       16      // pixel and weight width
`define CT_ACC_W    32      // accumulator width, wraps on overflow

`define CT_TM       2       // input channels
`define CT_TN       2       // output channels
`define CT_TR       4       // tile rows
`define CT_TC       4       // tile columns
`define CT_K        3       // kernel size, stride is 1

`define CT_OR       (`CT_TR - `CT_K + 1)
`define CT_OC       (`CT_TC - `CT_K + 1)

// load stream is input tile, then weights, then partial sums
`define CT_IN_WORDS (`CT_TM * `CT_TR * `CT_TC)
`define CT_W_WORDS  (`CT_TN * `CT_TM * `CT_K * `CT_K)
`define CT_PS_WORDS (`CT_TN * `CT_OR * `CT_OC)

`define CT_TERMS    (`CT_TM * `CT_K * `CT_K)    // MAC terms per output

`endif

// ==== verilog/conv_tile_data_pkg.sv ====
// data types carried between the loader, the MAC pipeline and the store
// import where pixels, accumulators or output beats are handled
`include "conv_tile_defines.svh"

package conv_tile_data_pkg;

    typedef logic signed [`CT_DW-1:0]    pixel_t;   // pixel or weight
    typedef logic signed [`CT_ACC_W-1:0] acc_t;     // partial sum and result

    // operand set for one MAC step
    typedef struct packed {
        pixel_t x;      // input pixel
        pixel_t w;      // weight
        acc_t   psum;   // seed for the first term
    } tile_operand_t;

    // one beat of the output stream
    typedef struct packed {
        acc_t data;
        logic last;     // final output of the tile
    } store_beat_t;

endpackage

// ==== verilog/conv_tile_ctrl_pkg.sv ====
// control types for the tile phase and the loop indices
// shared by the FSM, the loop counter and the data path
package conv_tile_ctrl_pkg;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_LOAD,
        PH_COMPUTE,
        PH_STORE,
        PH_DONE
    } tile_phase_t;

    // compute runs all six fields, store only n/orow/ocol
    typedef struct packed {
        logic [2:0] n;      // output channel, outermost
        logic [2:0] orow;
        logic [2:0] ocol;
        logic [2:0] m;      // input channel
        logic [2:0] kr;
        logic [2:0] kc;     // innermost
        logic [7:0] lin;    // steps taken in this phase
    } loop_idx_t;

endpackage

// ==== verilog/conv_tile_fsm.sv ====
// phase FSM of the tile engine: idle, load, compute with drain, store, done
// forms the counter step from the stream handshakes
`timescale 1ns/1ps

module conv_tile_fsm (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            load_fire,
    input  logic                            out_fire,
    input  logic                            wrap,
    output conv_tile_ctrl_pkg::tile_phase_t phase,
    output logic                            step,
    output logic                            busy,
    output logic                            done
);
    import conv_tile_ctrl_pkg::*;

    localparam logic [1:0] DRAIN = 2'd2;   // MAC terms still in flight at wrap

    logic [1:0] drain_cnt;                  // zero while the counter runs

    always_comb begin
        case (phase)
            PH_LOAD:    step = load_fire;
            PH_COMPUTE: step = (drain_cnt == 2'd0);    // one term per cycle
            PH_STORE:   step = out_fire;
            default:    step = 1'b0;
        endcase
    end

    assign busy = (phase != PH_IDLE);
    assign done = (phase == PH_DONE);   // single cycle, state leaves at once

    always_ff @(posedge clk) begin
        if (reset) begin
            phase     <= PH_IDLE;
            drain_cnt <= 2'd0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (start)
                        phase <= PH_LOAD;
                end
                PH_LOAD: begin
                    if (step && wrap)
                        phase <= PH_COMPUTE;   // last load word accepted
                end
                PH_COMPUTE: begin
                    if (drain_cnt == DRAIN) begin
                        phase     <= PH_STORE;
                        drain_cnt <= 2'd0;
                    end else if (drain_cnt != 2'd0 || wrap) begin
                        drain_cnt <= drain_cnt + 2'd1;
                    end
                end
                PH_STORE: begin
                    if (step && wrap)
                        phase <= PH_DONE;
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    a_phase_legal: assert property (@(posedge clk) disable iff (reset)
        phase inside {PH_IDLE, PH_LOAD, PH_COMPUTE, PH_STORE, PH_DONE})
        else $error("illegal tile phase %0d", phase);

    // a start during a running tile must not reopen the load
    a_start_ignored: assert property (@(posedge clk) disable iff (reset)
        (start && phase inside {PH_COMPUTE, PH_STORE, PH_DONE}) |=> phase != PH_LOAD)
        else $error("start restarted a busy tile");

endmodule

// ==== verilog/tile_counter.sv ====
// nested loop counter shared by all phases, cleared on each phase change
// wrap marks the final step of load, compute or store
`timescale 1ns/1ps
`include "conv_tile_defines.svh"

module tile_counter (
    input  logic                            clk,
    input  logic                            reset,
    input  conv_tile_ctrl_pkg::tile_phase_t phase,
    input  logic                            step,
    output conv_tile_ctrl_pkg::loop_idx_t   idx,
    output logic                            wrap
);
    import conv_tile_ctrl_pkg::*;

    localparam int LOAD_LAST = `CT_IN_WORDS + `CT_W_WORDS + `CT_PS_WORDS - 1;
    localparam int MAX_LIN   = `CT_PS_WORDS * `CT_TERMS;

    tile_phase_t phase_q;
    loop_idx_t   idx_q;
    loop_idx_t   idx_next;
    logic        kc_end;
    logic        kr_end;
    logic        m_end;
    logic        ocol_end;
    logic        orow_end;
    logic        n_end;
    logic        carry_m;   // kernel loops done, or skipped in store

    assign idx = (phase != phase_q) ? '0 : idx_q;   // new phase starts at zero

    assign kc_end   = (idx.kc == 3'(`CT_K - 1));
    assign kr_end   = (idx.kr == 3'(`CT_K - 1));
    assign m_end    = (idx.m == 3'(`CT_TM - 1));
    assign ocol_end = (idx.ocol == 3'(`CT_OC - 1));
    assign orow_end = (idx.orow == 3'(`CT_OR - 1));
    assign n_end    = (idx.n == 3'(`CT_TN - 1));

    always_comb begin
        case (phase)
            PH_LOAD:    wrap = (idx.lin == 8'(LOAD_LAST));
            PH_COMPUTE: wrap = n_end && orow_end && ocol_end && m_end && kr_end && kc_end;
            PH_STORE:   wrap = n_end && orow_end && ocol_end;
            default:    wrap = 1'b0;
        endcase
    end

    always_comb begin
        idx_next     = idx;
        idx_next.lin = idx.lin + 8'd1;
        carry_m      = (phase == PH_COMPUTE) ? (kc_end && kr_end && m_end) : 1'b1;
        if (phase == PH_COMPUTE) begin
            idx_next.kc = kc_end ? 3'd0 : idx.kc + 3'd1;
            if (kc_end)
                idx_next.kr = kr_end ? 3'd0 : idx.kr + 3'd1;
            if (kc_end && kr_end)
                idx_next.m = m_end ? 3'd0 : idx.m + 3'd1;
        end
        if (phase == PH_COMPUTE || phase == PH_STORE) begin
            if (carry_m)
                idx_next.ocol = ocol_end ? 3'd0 : idx.ocol + 3'd1;
            if (carry_m && ocol_end)
                idx_next.orow = orow_end ? 3'd0 : idx.orow + 3'd1;
            if (carry_m && ocol_end && orow_end)
                idx_next.n = n_end ? 3'd0 : idx.n + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase_q <= PH_IDLE;
            idx_q   <= '0;
        end else begin
            phase_q <= phase;
            idx_q   <= step ? idx_next : idx;
        end
    end

    a_idx_range: assert property (@(posedge clk) disable iff (reset)
        idx.kc < `CT_K && idx.kr < `CT_K && idx.m < `CT_TM &&
        idx.ocol < `CT_OC && idx.orow < `CT_OR && idx.n < `CT_TN && idx.lin <= MAX_LIN)
        else $error("loop index out of range");

endmodule

// ==== verilog/tile_loader.sv ====
// takes the load stream into the input, weight and partial-sum buffers
// and registers one MAC operand set per cycle, addressed by the loop index
`timescale 1ns/1ps
`include "conv_tile_defines.svh"

module tile_loader (
    input  logic                              clk,
    input  logic                              reset,
    input  conv_tile_ctrl_pkg::tile_phase_t   phase,
    input  conv_tile_ctrl_pkg::loop_idx_t     idx,
    input  conv_tile_data_pkg::pixel_t        load_data,
    input  logic                              load_valid,
    output logic                              load_ready,
    output conv_tile_data_pkg::tile_operand_t operand
);
    import conv_tile_ctrl_pkg::*;
    import conv_tile_data_pkg::*;

    localparam int W_BASE     = `CT_IN_WORDS;
    localparam int PS_BASE    = `CT_IN_WORDS + `CT_W_WORDS;
    localparam int LOAD_WORDS = PS_BASE + `CT_PS_WORDS;
    localparam int X_AW       = $clog2(`CT_IN_WORDS);
    localparam int W_AW       = $clog2(`CT_W_WORDS);
    localparam int PS_AW      = $clog2(`CT_PS_WORDS);

    pixel_t           in_mem [`CT_IN_WORDS];   // m, row, col
    pixel_t           w_mem  [`CT_W_WORDS];    // n, m, kr, kc
    acc_t             ps_mem [`CT_PS_WORDS];   // n, orow, ocol
    logic             load_fire;
    logic [X_AW-1:0]  x_addr;
    logic [W_AW-1:0]  w_addr;
    logic [PS_AW-1:0] ps_addr;

    assign load_ready = (phase == PH_LOAD);
    assign load_fire  = load_valid && load_ready;

    // window position for stride 1
    assign x_addr  = X_AW'(idx.m * (`CT_TR * `CT_TC) + (idx.orow + idx.kr) * `CT_TC
                           + idx.ocol + idx.kc);
    assign w_addr  = W_AW'(((idx.n * `CT_TM + idx.m) * `CT_K + idx.kr) * `CT_K + idx.kc);
    assign ps_addr = PS_AW'(idx.n * (`CT_OR * `CT_OC) + idx.orow * `CT_OC + idx.ocol);

    always_ff @(posedge clk) begin
        if (load_fire) begin
            if (idx.lin < W_BASE)
                in_mem[X_AW'(idx.lin)] <= load_data;
            else if (idx.lin < PS_BASE)
                w_mem[W_AW'(idx.lin - W_BASE)] <= load_data;
            else
                ps_mem[PS_AW'(idx.lin - PS_BASE)] <= acc_t'(load_data);  // sign extend
        end
        operand.x    <= in_mem[x_addr];
        operand.w    <= w_mem[w_addr];
        operand.psum <= ps_mem[ps_addr];
    end

    // every accepted word must land inside the three buffers
    a_load_in_range: assert property (@(posedge clk) disable iff (reset)
        load_fire |-> idx.lin < 8'(LOAD_WORDS))
        else $error("load word %0d beyond tile", idx.lin);

endmodule

// ==== verilog/conv_mac_array.sv ====
// two-stage multiply-accumulate over the term sequence of each output
// stage 1 holds the product, stage 2 seeds or adds and emits on the last term
`timescale 1ns/1ps
`include "conv_tile_defines.svh"

module conv_mac_array (
    input  logic                              clk,
    input  logic                              reset,
    input  conv_tile_ctrl_pkg::tile_phase_t   phase,
    input  conv_tile_ctrl_pkg::loop_idx_t     idx,
    input  conv_tile_data_pkg::tile_operand_t operand,
    output conv_tile_data_pkg::acc_t          result,
    output logic                              result_valid,
    output logic [$clog2(`CT_PS_WORDS)-1:0]   result_addr
);
    import conv_tile_ctrl_pkg::*;
    import conv_tile_data_pkg::*;

    localparam int AW    = $clog2(`CT_PS_WORDS);
    localparam int TOTAL = `CT_PS_WORDS * `CT_TERMS;   // counter steps in compute

    // flags that travel alongside the loader's operand register
    logic          s0_valid;
    logic          s0_first;
    logic          s0_last;
    logic [AW-1:0] s0_addr;

    logic          s1_valid;
    logic          s1_first;
    logic          s1_last;
    logic [AW-1:0] s1_addr;
    acc_t          s1_prod;
    acc_t          s1_psum;

    acc_t          acc;
    acc_t          acc_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            s0_valid <= 1'b0;
            s1_valid <= 1'b0;
        end else begin
            s0_valid <= (phase == PH_COMPUTE) && (idx.lin < 8'(TOTAL));  // drain is idle
            s1_valid <= s0_valid;
        end
    end

    always_ff @(posedge clk) begin
        s0_first <= (idx.m == 3'd0) && (idx.kr == 3'd0) && (idx.kc == 3'd0);
        s0_last  <= (idx.m == 3'(`CT_TM - 1)) && (idx.kr == 3'(`CT_K - 1))
                    && (idx.kc == 3'(`CT_K - 1));
        s0_addr  <= AW'(idx.n * (`CT_OR * `CT_OC) + idx.orow * `CT_OC + idx.ocol);

        s1_first <= s0_first;
        s1_last  <= s0_last;
        s1_addr  <= s0_addr;
        s1_prod  <= acc_t'(operand.x) * acc_t'(operand.w);  // signed, wraps at 32 bits
        s1_psum  <= operand.psum;

        if (s1_valid)
            acc <= acc_next;
    end

    assign acc_next     = s1_first ? (s1_psum + s1_prod) : (acc + s1_prod);
    assign result       = acc_next;
    assign result_valid = s1_valid && s1_last;
    assign result_addr  = s1_addr;

endmodule

// ==== verilog/tile_store.sv ====
// holds the finished outputs and streams them with valid/ready
// beat order follows the store index, last on the final output
`timescale 1ns/1ps
`include "conv_tile_defines.svh"

module tile_store (
    input  logic                            clk,
    input  logic                            reset,
    input  conv_tile_ctrl_pkg::tile_phase_t phase,
    input  conv_tile_ctrl_pkg::loop_idx_t   idx,
    input  conv_tile_data_pkg::acc_t        result,
    input  logic                            result_valid,
    input  logic [$clog2(`CT_PS_WORDS)-1:0] result_addr,
    output conv_tile_data_pkg::store_beat_t out_beat,
    output logic                            out_valid,
    input  logic                            out_ready
);
    import conv_tile_ctrl_pkg::*;
    import conv_tile_data_pkg::*;

    localparam int AW = $clog2(`CT_PS_WORDS);

    acc_t          res_mem [`CT_PS_WORDS];
    logic [AW-1:0] rd_addr;

    always_ff @(posedge clk) begin
        if (result_valid)
            res_mem[result_addr] <= result;
    end

    assign rd_addr = AW'(idx.n * (`CT_OR * `CT_OC) + idx.orow * `CT_OC + idx.ocol);

    // index only moves on a handshake, so the beat holds while stalled
    assign out_valid     = (phase == PH_STORE);
    assign out_beat.data = res_mem[rd_addr];
    assign out_beat.last = (rd_addr == AW'(`CT_PS_WORDS - 1));

    a_beat_stable: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> out_valid && $stable(out_beat))
        else $error("output beat changed before it was accepted");

endmodule

// ==== verilog/conv_tile_top.sv ====
// single-tile convolution engine: load stream in, MAC over the tile,
// output stream out; start opens a tile and done closes it
`timescale 1ns/1ps
`include "conv_tile_defines.svh"

module conv_tile_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  conv_tile_data_pkg::pixel_t      load_data,
    input  logic                            load_valid,
    output logic                            load_ready,
    output conv_tile_data_pkg::store_beat_t out_beat,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic                            busy,
    output logic                            done
);
    import conv_tile_ctrl_pkg::*;
    import conv_tile_data_pkg::*;

    tile_phase_t                     phase;
    loop_idx_t                       idx;
    logic                            step;
    logic                            wrap;
    logic                            load_fire;
    logic                            out_fire;
    tile_operand_t                   operand;
    acc_t                            result;
    logic                            result_valid;
    logic [$clog2(`CT_PS_WORDS)-1:0] result_addr;

    assign load_fire = load_valid && load_ready;
    assign out_fire  = out_valid && out_ready;

    conv_tile_fsm conv_tile_fsm_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .load_fire (load_fire),
        .out_fire  (out_fire),
        .wrap      (wrap),
        .phase     (phase),
        .step      (step),
        .busy      (busy),
        .done      (done)
    );

    tile_counter tile_counter_inst (
        .clk   (clk),
        .reset (reset),
        .phase (phase),
        .step  (step),
        .idx   (idx),
        .wrap  (wrap)
    );

    tile_loader tile_loader_inst (
        .clk        (clk),
        .reset      (reset),
        .phase      (phase),
        .idx        (idx),
        .load_data  (load_data),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .operand    (operand)
    );

    conv_mac_array conv_mac_array_inst (
        .clk          (clk),
        .reset        (reset),
        .phase        (phase),
        .idx          (idx),
        .operand      (operand),
        .result       (result),
        .result_valid (result_valid),
        .result_addr  (result_addr)
    );

    tile_store tile_store_inst (
        .clk          (clk),
        .reset        (reset),
        .phase        (phase),
        .idx          (idx),
        .result       (result),
        .result_valid (result_valid),
        .result_addr  (result_addr),
        .out_beat     (out_beat),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

endmodule

// ==== sim/conv_tile_tb.sv ====
// self-checking testbench for the tile convolution engine
// runs each golden record through the load stream and checks the output stream
`timescale 1ns/1ps
`include "conv_tile_defines.svh"

module conv_tile_tb;
    import conv_tile_data_pkg::*;

    localparam int LOAD_WORDS  = `CT_IN_WORDS + `CT_W_WORDS + `CT_PS_WORDS;
    localparam int OUT_WORDS   = `CT_PS_WORDS;
    localparam int MAX_TESTS   = 16;
    localparam int TEST_CYCLES = LOAD_WORDS * 4 + 146 + OUT_WORDS * 4 + 50;
    localparam int SEED        = 32'h300c_ca80;

    logic        clk = 1'b0;
    logic        reset;
    logic        start;
    pixel_t      load_data;
    logic        load_valid;
    logic        load_ready;
    store_beat_t out_beat;
    logic        out_valid;
    logic        out_ready;
    logic        busy;
    logic        done;

    logic [15:0]     stim_mem [MAX_TESTS][LOAD_WORDS];
    logic [31:0]     exp_mem  [MAX_TESTS][OUT_WORDS];
    logic [8*16-1:0] names    [MAX_TESTS];
    logic [8*16-1:0] modes    [MAX_TESTS];
    int              num_tests  = 0;
    int              errors     = 0;
    int              failed     = 0;
    int              done_seen  = 0;
    int              beats_seen = 0;
    logic            loaded     = 1'b0;

    always #5 clk = ~clk;

    conv_tile_top conv_tile_top_inst (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .load_data  (load_data),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .busy       (busy),
        .done       (done)
    );

    // totals over the whole run, one done and eight beats per tile
    always @(negedge clk) begin
        if (!reset) begin
            if (done)
                done_seen++;
            if (out_valid && out_ready)
                beats_seen++;
        end
    end

    task automatic read_golden();
        int               fd;
        int               got;
        int               i;
        logic [8*128-1:0] line;
        fd = $fopen("sim/conv_tile_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file");
            errors++;
        end else begin
            got = $fgets(line, fd);     // skip the two column lines
            got = $fgets(line, fd);
            while (num_tests < MAX_TESTS
                   && $fscanf(fd, "%s %s", names[num_tests], modes[num_tests]) == 2) begin
                got = 0;
                for (i = 0; i < LOAD_WORDS; i++)
                    got += $fscanf(fd, "%h", stim_mem[num_tests][i]);
                for (i = 0; i < OUT_WORDS; i++)
                    got += $fscanf(fd, "%h", exp_mem[num_tests][i]);
                assert (got == LOAD_WORDS + OUT_WORDS) else begin
                    $display("golden record %0d is incomplete", num_tests);
                    errors++;
                end
                num_tests++;
            end
            $fclose(fd);
        end
    endtask

    // starts one tile, feeds the load stream, then takes beats until done
    task automatic run_tile(input int t);
        int          i;
        int          cyc;
        int          beats;
        int          errors_before;
        logic        gaps;
        logic        stalls;
        logic        stray;
        logic        held;
        logic        got_done;
        logic        last_fired;
        store_beat_t held_beat;
        errors_before = errors;
        gaps   = (modes[t] == "gaps") || (modes[t] == "mixed");
        stalls = (modes[t] == "stalls") || (modes[t] == "mixed");
        stray  = (modes[t] == "mixed");
        assert (!busy && !done && !out_valid && !load_ready) else begin
            $display("engine not idle before test %0s started", names[t]);
            errors++;
        end
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        i     = 0;
        held  = 1'b0;
        while (i < LOAD_WORDS) begin
            load_data  = stim_mem[t][i];
            load_valid = held || !gaps || ($urandom % 4 != 0);   // hold an unaccepted word
            @(negedge clk);
            assert (busy && load_ready) else begin
                $display("busy or load_ready low during the load of test %0s", names[t]);
                errors++;
            end
            if (load_valid && load_ready)
                i++;
            held = load_valid && !load_ready;
            @(posedge clk);
            #1;
        end
        load_valid = 1'b0;
        load_data  = '0;
        cyc        = 0;
        beats      = 0;
        held       = 1'b0;
        got_done   = 1'b0;
        last_fired = 1'b0;
        while (!got_done) begin
            out_ready = !stalls || ($urandom % 3 != 0);
            start     = stray && (cyc == 5 || beats == OUT_WORDS / 2);   // tile still busy
            @(negedge clk);
            assert (busy && !load_ready) else begin
                $display("busy low or load_ready high after the load in test %0s", names[t]);
                errors++;
            end
            if (held) begin
                assert (out_valid && out_beat == held_beat) else begin
                    $display("ERROR %0s stalled beat: expected %h, actual %h",
                             names[t], held_beat, out_beat);
                    errors++;
                end
            end
            if (out_valid && out_ready) begin
                assert (out_beat.data == exp_mem[t][beats]) else begin
                    $display("ERROR %0s beat %0d: expected %h, actual %h",
                             names[t], beats, exp_mem[t][beats], out_beat.data);
                    errors++;
                end
                assert (out_beat.last == (beats == OUT_WORDS - 1)) else begin
                    $display("ERROR %0s beat %0d last: expected %b, actual %b",
                             names[t], beats, beats == OUT_WORDS - 1, out_beat.last);
                    errors++;
                end
                beats++;
            end
            if (done) begin
                assert (last_fired) else begin
                    $display("done in test %0s did not follow the last beat", names[t]);
                    errors++;
                end
            end
            last_fired = out_valid && out_ready && out_beat.last;
            held       = out_valid && !out_ready;
            held_beat  = out_beat;
            got_done   = done;
            cyc++;
            @(posedge clk);
            #1;
        end
        start     = 1'b0;
        out_ready = 1'b0;
        assert (beats == OUT_WORDS) else begin
            $display("ERROR %0s beat count: expected %0d, actual %0d", names[t], OUT_WORDS, beats);
            errors++;
        end
        if (errors > errors_before)
            failed++;
        $display("test %0s (%0s): %0d beats, %0d errors",
                 names[t], modes[t], beats, errors - errors_before);
    endtask

    initial begin
        int t;
        int seed_ret;
        reset      = 1'b1;
        start      = 1'b0;
        load_data  = '0;
        load_valid = 1'b0;
        out_ready  = 1'b0;
        seed_ret   = $urandom(SEED);
        read_golden();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (t = 0; t < num_tests; t++)
            run_tile(t);
        assert (num_tests > 0) else begin
            $display("no test records were read from the golden file");
            errors++;
        end
        assert (done_seen == num_tests && beats_seen == num_tests * OUT_WORDS) else begin
            $display("ERROR totals: expected %0d done and %0d beats, actual %0d and %0d",
                     num_tests, num_tests * OUT_WORDS, done_seen, beats_seen);
            errors++;
        end
        $display("%0d tests run, %0d failed, %0d errors", num_tests, failed, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // run length scales with the number of golden records
    initial begin
        wait (loaded);
        repeat (num_tests * TEST_CYCLES + 10) @(posedge clk);
        $display("watchdog expired, the run hung before all tiles finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== conv_tile.f ====
+incdir+verilog
verilog/conv_tile_data_pkg.sv
verilog/conv_tile_ctrl_pkg.sv
verilog/conv_tile_fsm.sv
verilog/tile_counter.sv
verilog/tile_loader.sv
verilog/conv_mac_array.sv
verilog/tile_store.sv
verilog/conv_tile_top.sv
sim/conv_tile_tb.sv

// ==== Bender.yml ====
package:
  name: conv_tile

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/conv_tile_data_pkg.sv
      - verilog/conv_tile_ctrl_pkg.sv
      - verilog/conv_tile_fsm.sv
      - verilog/tile_counter.sv
      - verilog/tile_loader.sv
      - verilog/conv_mac_array.sv
      - verilog/tile_store.sv
      - verilog/conv_tile_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/conv_tile_tb.sv

// ==== sim/conv_tile_golden.txt ====
# record: test name, mode (plain gaps stalls mixed), 76 hex load words, 8 hex outputs
# load words: input tile m/row/col, weights n/m/kr/kc, psums; outputs in n/orow/ocol order
basic plain 0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010
0003 0001 0004 0001 0005 0009 0002 0006 0005 0003 0005 0008 0009 0007 0009 0003
0001 0002 0003 0004 0005 0006 0007 0008 0009 0000 0000 0000 0000 0001 0000 0000 0000 0000
ffff 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0003
000a 0014 001e 0028 ffff fffe fffd fffc
0000016f 0000019f 00000231 0000026a 0000000d 00000014 00000013 ffffffff
gaps gaps 0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010
0003 0001 0004 0001 0005 0009 0002 0006 0005 0003 0005 0008 0009 0007 0009 0003
0001 0002 0003 0004 0005 0006 0007 0008 0009 0000 0000 0000 0000 0001 0000 0000 0000 0000
ffff 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0003
000a 0014 001e 0028 ffff fffe fffd fffc
0000016f 0000019f 00000231 0000026a 0000000d 00000014 00000013 ffffffff
stalls stalls ffff fffe fffd fffc fffb fffa fff9 fff8 fff7 fff6 fff5 fff4 fff3 fff2 fff1 fff0
0000 0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f
0001 0001 0001 0001 0001 0001 0001 0001 0001 0002 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 fffd 0000 0000 0000 0000 0000 0000 0000 0000 0000 0005 0000 0000 0000
0064 00c8 012c 0190 ffce ffc4 ffba ffb0
0000002e 0000008b 000000da 00000137 fffffffe fffffffc 0000000a 00000008
wrap plain 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
7fff 8000 0000 ffff 0001 7fff 8000 ffff
80007fff 7fff8000 80000000 7fffffff 80090001 80097fff 80088000 8008ffff
mixed mixed 0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010
0003 0001 0004 0001 0005 0009 0002 0006 0005 0003 0005 0008 0009 0007 0009 0003
0001 0002 0003 0004 0005 0006 0007 0008 0009 0000 0000 0000 0000 0001 0000 0000 0000 0000
ffff 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0003
000a 0014 001e 0028 ffff fffe fffd fffc
0000016f 0000019f 00000231 0000026a 0000000d 00000014 00000013 ffffffff
